/* merge_consts.svh */
// ##############################
// frame merger sizes
// source count, fifo depth, sink credits and priority
// ##############################

`ifndef MERGE_CONSTS_SVH
`define MERGE_CONSTS_SVH

// number of producer ports
`define MERGE_NUM_SRC 4

// entries per source fifo, power of two
`define MERGE_FIFO_DEPTH 8

// sink buffer slots
`define MERGE_CREDITS 4

// sources that beat round robin
`define MERGE_PRIO_MASK 4'b0100

`endif

/* merge_pkg.sv */
// ##############################
// frame merger shared types
// ##############################

`default_nettype none

`include "merge_consts.svh"

package merge_pkg;

    typedef logic [31:0] word_t;                                    // one data word
    typedef logic [$clog2(`MERGE_NUM_SRC)-1:0] src_sel_t;           // source index
    typedef logic [`MERGE_NUM_SRC-1:0] src_mask_t;                  // one bit per source
    typedef logic [$clog2(`MERGE_CREDITS+1)-1:0] credit_cnt_t;      // 0 .. MERGE_CREDITS
    typedef logic [$clog2(`MERGE_FIFO_DEPTH+1)-1:0] fifo_cnt_t;     // 0 .. depth

    // frame position of a source as seen from the output side
    typedef enum logic {
        FRAME_IDLE,
        FRAME_ACTIVE
    } frame_state_t;

endpackage

`default_nettype wire

/* source_fifo.sv */
// ##############################
// per-producer word FIFO
// tracks frame state and raises the hold request
// ##############################

`default_nettype none

`include "merge_consts.svh"

module source_fifo (
    input  wire                  CLK,
    input  wire                  RST,
    input  wire                  in_valid,
    input  wire merge_pkg::word_t in_data,
    input  wire                  in_last,
    input  wire                  grant,
    output logic                 in_full,
    output logic                 write_req,
    output logic                 hold_req,
    output merge_pkg::word_t     head_data,
    output logic                 head_last
);

    localparam int PTR_W = $clog2(`MERGE_FIFO_DEPTH);

    merge_pkg::word_t        mem_data [`MERGE_FIFO_DEPTH];
    logic                    mem_last [`MERGE_FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    merge_pkg::fifo_cnt_t    count;
    merge_pkg::frame_state_t state;
    logic                    push;
    logic                    pop;

    assign in_full   = (count == merge_pkg::fifo_cnt_t'(`MERGE_FIFO_DEPTH));
    assign write_req = (count != '0);                 // not empty
    assign push      = in_valid && !in_full;          // writes while full are dropped
    assign pop       = grant && write_req;
    assign head_data = mem_data[rd_ptr];
    assign head_last = mem_last[rd_ptr];
    assign hold_req  = (state == merge_pkg::FRAME_ACTIVE) && write_req;

    // ##############################
    // storage and pointers
    // ##############################

    always_ff @(posedge CLK) begin
        if (push) begin
            mem_data[wr_ptr] <= in_data;
            mem_last[wr_ptr] <= in_last;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;                  // wraps at depth
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                  // both or neither
            endcase
        end
    end

    // ##############################
    // frame tracking
    // ##############################

    always_ff @(posedge CLK) begin
        if (RST)
            state <= merge_pkg::FRAME_IDLE;
        else if (pop)
            state <= head_last ? merge_pkg::FRAME_IDLE : merge_pkg::FRAME_ACTIVE;
    end

    // producer must watch in_full before writing
    a_no_write_full: assert property (@(posedge CLK) disable iff (RST)
        in_valid |-> !in_full)
        else $error("source_fifo: write while full, word dropped");

    // arbiter only grants sources that request
    a_no_grant_empty: assert property (@(posedge CLK) disable iff (RST)
        grant |-> write_req)
        else $error("source_fifo: grant while empty");

endmodule

`default_nettype wire

/* rrp_arbiter.sv */
// ##############################
// round-robin arbiter with priority mask and frame hold
// selects one source and muxes its head word
// ##############################

`default_nettype none

`include "merge_consts.svh"

module rrp_arbiter #(
    parameter merge_pkg::src_mask_t PRIORITY = '0
) (
    input  wire                                          CLK,
    input  wire                                          RST,
    input  wire merge_pkg::src_mask_t                    write_req,
    input  wire merge_pkg::src_mask_t                    hold_req,
    input  wire merge_pkg::word_t [`MERGE_NUM_SRC-1:0]   data_in,
    input  wire merge_pkg::src_mask_t                    last_in,
    input  wire                                          ready,
    output merge_pkg::src_mask_t                         grant,
    output logic                                         write_out,
    output merge_pkg::word_t                             data_out,
    output logic                                         last_out,
    output merge_pkg::src_sel_t                          sel_out
);

    merge_pkg::src_mask_t prio_req;
    merge_pkg::src_sel_t  sel;
    merge_pkg::src_sel_t  held_sel;     // selection frozen while sink stalls
    merge_pkg::src_sel_t  rr_ptr;       // last round-robin winner
    logic                 rr_mode;      // current pick came from round robin
    logic                 held_rr;
    logic                 hold;

    assign prio_req = PRIORITY & write_req;

    // ##############################
    // source selection
    // ##############################

    always_comb begin
        sel     = '0;
        rr_mode = 1'b0;
        if (hold) begin
            sel     = held_sel;
            rr_mode = held_rr;
        end else if (|hold_req) begin
            for (int i = `MERGE_NUM_SRC - 1; i >= 0; i--) begin
                if (hold_req[i])
                    sel = merge_pkg::src_sel_t'(i);       // lowest mid-frame source
            end
        end else if (|prio_req) begin
            for (int i = `MERGE_NUM_SRC - 1; i >= 0; i--) begin
                if (prio_req[i])
                    sel = merge_pkg::src_sel_t'(i);
            end
        end else if (|write_req) begin
            rr_mode = 1'b1;
            // nearest requester after the pointer wins
            for (int k = `MERGE_NUM_SRC; k >= 1; k--) begin
                if (write_req[merge_pkg::src_sel_t'(rr_ptr + k)])
                    sel = merge_pkg::src_sel_t'(rr_ptr + k);
            end
        end
    end

    // a pending frame hold blocks every other source
    assign write_out = (|write_req) && (!(|hold_req) || hold_req[sel]);
    assign grant     = merge_pkg::src_mask_t'(write_out && ready) << sel;
    assign data_out  = data_in[sel];
    assign last_out  = last_in[sel];
    assign sel_out   = sel;

    always_ff @(posedge CLK) begin
        if (RST) begin
            hold     <= 1'b0;
            held_sel <= '0;
            held_rr  <= 1'b0;
            rr_ptr   <= merge_pkg::src_sel_t'(`MERGE_NUM_SRC - 1);  // source 0 goes first
        end else begin
            if (ready)
                hold <= 1'b0;
            else if (write_out)
                hold <= 1'b1;                             // sink stalled on a word
            if (!hold) begin
                held_sel <= sel;
                held_rr  <= rr_mode;
            end
            if (rr_mode && |grant)
                rr_ptr <= sel;
        end
    end

    a_grant_onehot: assert property (@(posedge CLK) disable iff (RST)
        $onehot0(grant))
        else $error("rrp_arbiter: grant not one-hot");

endmodule

`default_nettype wire

/* credit_sender.sv */
// ##############################
// sink output register stage
// spends one credit per word, counts returns
// ##############################

`default_nettype none

`include "merge_consts.svh"

module credit_sender (
    input  wire                      CLK,
    input  wire                      RST,
    input  wire                      write_in,
    input  wire merge_pkg::word_t    data_in,
    input  wire                      last_in,
    input  wire merge_pkg::src_sel_t src_in,
    input  wire                      credit_return,
    output logic                     ready,
    output logic                     out_valid,
    output merge_pkg::word_t         out_data,
    output logic                     out_last,
    output merge_pkg::src_sel_t      out_src
);

    merge_pkg::credit_cnt_t credits;
    logic                   accept;

    assign ready  = (credits != '0);
    assign accept = write_in && ready;

    always_ff @(posedge CLK) begin
        if (RST) begin
            credits   <= merge_pkg::credit_cnt_t'(`MERGE_CREDITS);
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;       // word sent
                2'b01:   credits <= credits + 1'b1;       // slot freed
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            out_data <= data_in;
            out_last <= last_in;
            out_src  <= src_in;
        end
    end

    // sink returns no more slots than it has
    a_credit_max: assert property (@(posedge CLK) disable iff (RST)
        credits <= merge_pkg::credit_cnt_t'(`MERGE_CREDITS))
        else $error("credit_sender: credit count above sink size");

endmodule

`default_nettype wire

/* merge_top.sv */
// ##############################
// frame merger top level
// four source FIFOs, arbiter, credit sender
// ##############################

`default_nettype none

`include "merge_consts.svh"

module merge_top (
    input  wire                                          CLK,
    input  wire                                          RST,
    input  wire merge_pkg::src_mask_t                    in_valid,
    input  wire merge_pkg::word_t [`MERGE_NUM_SRC-1:0]   in_data,
    input  wire merge_pkg::src_mask_t                    in_last,
    output merge_pkg::src_mask_t                         in_full,
    output logic                                         out_valid,
    output merge_pkg::word_t                             out_data,
    output logic                                         out_last,
    output merge_pkg::src_sel_t                          out_src,
    input  wire                                          credit_return
);

    merge_pkg::src_mask_t                    write_req;
    merge_pkg::src_mask_t                    hold_req;
    merge_pkg::src_mask_t                    head_last;
    merge_pkg::src_mask_t                    grant;
    merge_pkg::word_t [`MERGE_NUM_SRC-1:0]   head_data;
    logic                                    arb_write;
    merge_pkg::word_t                        arb_data;
    logic                                    arb_last;
    merge_pkg::src_sel_t                     arb_sel;
    logic                                    ready;

    for (genvar i = 0; i < `MERGE_NUM_SRC; i++) begin : gen_src
        source_fifo fifo_inst (
            .CLK       (CLK),
            .RST       (RST),
            .in_valid  (in_valid[i]),
            .in_data   (in_data[i]),
            .in_last   (in_last[i]),
            .grant     (grant[i]),
            .in_full   (in_full[i]),
            .write_req (write_req[i]),
            .hold_req  (hold_req[i]),
            .head_data (head_data[i]),
            .head_last (head_last[i])
        );
    end

    rrp_arbiter #(
        .PRIORITY (`MERGE_PRIO_MASK)
    ) arb_inst (
        .CLK       (CLK),
        .RST       (RST),
        .write_req (write_req),
        .hold_req  (hold_req),
        .data_in   (head_data),
        .last_in   (head_last),
        .ready     (ready),
        .grant     (grant),
        .write_out (arb_write),
        .data_out  (arb_data),
        .last_out  (arb_last),
        .sel_out   (arb_sel)
    );

    credit_sender sender_inst (
        .CLK           (CLK),
        .RST           (RST),
        .write_in      (arb_write),
        .data_in       (arb_data),
        .last_in       (arb_last),
        .src_in        (arb_sel),
        .credit_return (credit_return),
        .ready         (ready),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_last      (out_last),
        .out_src       (out_src)
    );

endmodule

`default_nettype wire

/* merge_tb.sv */
// ##############################
// frame merger testbench
// replays the trace and checks the sink port
// ##############################

`default_nettype none

`include "merge_consts.svh"

module merge_tb;

    logic                                  CLK;
    logic                                  RST;
    merge_pkg::src_mask_t                  in_valid;
    merge_pkg::word_t [`MERGE_NUM_SRC-1:0] in_data;
    merge_pkg::src_mask_t                  in_last;
    merge_pkg::src_mask_t                  in_full;
    logic                                  out_valid;
    merge_pkg::word_t                      out_data;
    logic                                  out_last;
    merge_pkg::src_sel_t                   out_src;
    logic                                  credit_return;

    merge_pkg::src_mask_t                  w_valid [$];   // one entry per W line
    merge_pkg::src_mask_t                  w_last [$];
    merge_pkg::word_t [`MERGE_NUM_SRC-1:0] w_data [$];
    merge_pkg::src_sel_t                   e_src [$];     // delivery order
    merge_pkg::word_t                      e_data [$];
    logic                                  e_last [$];
    int                                    due [$];       // return cycle per word in sink
    int                                    seen = 0;
    int                                    cycle = 0;
    logic [31:0]                           rnd = 32'd56151;

    merge_top merge_top_inst (.*);

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input merge_pkg::word_t exp, got);
        if (got !== exp) begin
            $display("[FAIL] %s: expected %h, got %h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_src(input string name, input merge_pkg::src_sel_t exp, got);
        if (got !== exp) begin
            $display("[FAIL] %s: expected %h, got %h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_last(input string name, input logic exp, got);
        if (got !== exp) begin
            $display("[FAIL] %s: expected %h, got %h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_mask(input string name, input merge_pkg::src_mask_t exp, got);
        if (got !== exp) begin
            $display("[FAIL] %s: expected %h, got %h", name, exp, got);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // W lines are stimulus, E lines the expected sink words
    task automatic load_trace();
        int                   fd;
        byte                  kind;
        merge_pkg::src_mask_t v;
        merge_pkg::src_mask_t l;
        merge_pkg::word_t     d [`MERGE_NUM_SRC];
        fd = $fopen("merge_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open merge_trace.txt");
            abort_run();
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "W") begin
                void'($fscanf(fd, "%h %h %h %h %h %h", v, l, d[0], d[1], d[2], d[3]));
                w_valid.push_back(v);
                w_last.push_back(l);
                w_data.push_back({d[3], d[2], d[1], d[0]});
            end else if (kind == "E") begin
                void'($fscanf(fd, "%h %h %h", v, d[0], l));      // src, data, last
                e_src.push_back(merge_pkg::src_sel_t'(v));
                e_data.push_back(d[0]);
                e_last.push_back(l[0]);
            end else begin
                $display("trace line starts with unknown kind %c", kind);
                abort_run();
            end
        end
        $fclose(fd);
    endtask

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    initial begin
        RST           = 1'b1;
        in_valid      = '0;
        in_data       = '0;
        in_last       = '0;
        credit_return = 1'b0;
        load_trace();
        repeat (8) @(posedge CLK);
        RST <= 1'b0;
        foreach (w_valid[i]) begin
            @(posedge CLK);
            check_mask("in_full", '0, in_full);           // trace stays below fifo depth
            in_valid <= w_valid[i];                      // all sources in one cycle
            in_data  <= w_data[i];
            in_last  <= w_last[i];
        end
        @(posedge CLK);
        in_valid <= '0;
        in_last  <= '0;
        wait (seen == e_data.size());
        repeat (4) @(posedge CLK);                       // room for stray words
        $display("** PASS **");
        $finish;
    end

    // watchdog, 40 cycles per trace line
    initial begin
        @(posedge CLK);
        repeat (40 * (w_valid.size() + e_data.size())) @(posedge CLK);
        $display("timeout with %0d of %0d words delivered", seen, e_data.size());
        abort_run();
    end

    // ##############################
    // sink model and output checks
    // ##############################

    always @(posedge CLK) begin
        if (!RST) begin
            cycle++;
            if (out_valid) begin
                if (seen >= e_data.size()) begin
                    $display("a word arrived after the whole expected sequence");
                    abort_run();
                end
                check_src("out_src", e_src[seen], out_src);
                check_word("out_data", e_data[seen], out_data);
                check_last("out_last", e_last[seen], out_last);
                seen++;
                rnd = xorshift32(rnd);
                due.push_back(cycle + int'(rnd % 4));     // slot freed 0 to 3 cycles later
                if (due.size() > `MERGE_CREDITS) begin
                    $display("sink received more words than it has buffer slots");
                    abort_run();
                end
            end
            if (due.size() > 0 && due[0] <= cycle) begin
                credit_return <= 1'b1;
                void'(due.pop_front());
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
merge_pkg.sv
source_fifo.sv
rrp_arbiter.sv
credit_sender.sv
merge_top.sv
merge_tb.sv

/* Bender.yml */
package:
  name: frame_merger

export_include_dirs:
  - .

sources:
  - merge_pkg.sv
  - source_fifo.sv
  - rrp_arbiter.sv
  - credit_sender.sv
  - merge_top.sv
  - target: test
    files:
      - merge_tb.sv

/* merge_trace.txt */
W f 0 A0010000 A1010000 A2010000 A3010000
W f f A0010001 A1010001 A2010001 A3010001
W b b A0020000 A1020000 00000000 A3020000
E 2 A2010000 0
E 2 A2010001 1
E 0 A0010000 0
E 0 A0010001 1
E 1 A1010000 0
E 1 A1010001 1
E 3 A3010000 0
E 3 A3010001 1
E 0 A0020000 1
E 1 A1020000 1
E 3 A3020000 1
